// File: source/div_pkg.sv
package div_pkg;

    // default operand width of the unit.
    localparam int data_width = 32;

    // risc-v m extension divide opcodes.
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_e;

    // operations that skip the array result.
    typedef enum logic [1:0] {
        sp_none     = 2'd0,
        sp_div_zero = 2'd1,
        sp_overflow = 2'd2
    } special_e;

    // decoded per-operation control, follows the operands down the pipe.
    typedef struct packed {
        logic neg_quot;
        logic neg_rem;
        logic sel_rem;
        logic special;
    } div_flags_t;

endpackage

// File: source/cpu_tag_pkg.sv
package cpu_tag_pkg;

    // physical register file has 128 entries.
    localparam int preg_width = 7;
    localparam int pc_width   = 32;

    // identifies the instruction a result belongs to.
    typedef struct packed {
        logic [preg_width-1:0] preg;
        logic [pc_width-1:0]   pc;
    } op_tag_t;

endpackage

// File: source/div_if.sv
// decoded operation, issue control to divide array.
interface div_op_if #(
    parameter int WIDTH = div_pkg::data_width
);
    logic                 valid;
    logic [WIDTH-1:0]     dividend_mag;
    logic [WIDTH-1:0]     divisor_mag;
    logic [WIDTH-1:0]     dividend_raw;
    div_pkg::div_flags_t  flags;
    div_pkg::special_e    special;
    cpu_tag_pkg::op_tag_t tag;

    modport src (
        output valid, dividend_mag, divisor_mag, dividend_raw, flags, special, tag
    );
    modport dst (
        input valid, dividend_mag, divisor_mag, dividend_raw, flags, special, tag
    );
endinterface

// unsigned array result, divide array to result fixup.
interface div_res_if #(
    parameter int WIDTH = div_pkg::data_width
);
    logic                 valid;
    logic [WIDTH-1:0]     quot_mag;
    logic [WIDTH-1:0]     rem_mag;
    logic [WIDTH-1:0]     dividend_raw;
    div_pkg::div_flags_t  flags;
    div_pkg::special_e    special;
    cpu_tag_pkg::op_tag_t tag;

    modport src (
        output valid, quot_mag, rem_mag, dividend_raw, flags, special, tag
    );
    modport dst (
        input valid, quot_mag, rem_mag, dividend_raw, flags, special, tag
    );
endinterface

// File: source/div_issue_ctrl.sv
module div_issue_ctrl #(
    parameter int WIDTH = div_pkg::data_width
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  div_pkg::div_op_e     op,
    input  logic [WIDTH-1:0]     dividend,
    input  logic [WIDTH-1:0]     divisor,
    input  cpu_tag_pkg::op_tag_t tag,
    div_op_if.src                op_out
);

    localparam logic [WIDTH-1:0] most_neg = {1'b1, {(WIDTH-1){1'b0}}};

    logic                is_signed;
    logic                sel_rem;
    logic                dvd_neg;
    logic                dvs_neg;
    logic [WIDTH-1:0]    dvd_mag;
    logic [WIDTH-1:0]    dvs_mag;
    logic                div_zero;
    logic                overflow;
    div_pkg::special_e   kind;
    div_pkg::div_flags_t flags;

    // opcode decode.
    assign is_signed = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
    assign sel_rem   = (op == div_pkg::op_rem) || (op == div_pkg::op_remu);

    // magnitudes for the unsigned array.
    assign dvd_neg = is_signed & dividend[WIDTH-1];
    assign dvs_neg = is_signed & divisor[WIDTH-1];
    assign dvd_mag = dvd_neg ? -dividend : dividend;
    assign dvs_mag = dvs_neg ? -divisor : divisor;

    assign div_zero = (divisor == '0);
    assign overflow = is_signed && (dividend == most_neg) && (divisor == '1);

    always_comb begin
        if (div_zero) begin
            kind = div_pkg::sp_div_zero;
        end else if (overflow) begin
            kind = div_pkg::sp_overflow;
        end else begin
            kind = div_pkg::sp_none;
        end
    end

    // remainder keeps the dividend sign.
    assign flags = '{
        neg_quot: dvd_neg ^ dvs_neg,
        neg_rem:  dvd_neg,
        sel_rem:  sel_rem,
        special:  (kind != div_pkg::sp_none)
    };

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_out.valid <= 1'b0;
        end else begin
            op_out.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_out.dividend_mag <= dvd_mag;
            op_out.divisor_mag  <= dvs_mag;
            op_out.dividend_raw <= dividend;
            op_out.flags        <= flags;
            op_out.special      <= kind;
            op_out.tag          <= tag;
        end
    end

    // an issued operation must arrive fully known.
    a_issue_known: assert property (
        @(posedge clk) disable iff (reset)
        issue |-> !$isunknown({op, dividend, divisor, tag})
    ) else $error("divide issue with unknown operands or tag");

endmodule

// File: source/div_array.sv
module div_array #(
    parameter int WIDTH = div_pkg::data_width
) (
    input  logic  clk,
    input  logic  reset,
    div_op_if.dst op_in,
    div_res_if.src res_out
);

    // everything a stage carries besides valid.
    typedef struct packed {
        logic [2*WIDTH-1:0]   pr;
        logic [WIDTH-1:0]     divisor;
        logic [WIDTH-1:0]     dividend_raw;
        div_pkg::div_flags_t  flags;
        div_pkg::special_e    special;
        cpu_tag_pkg::op_tag_t tag;
    } stage_t;

    stage_t pay_q   [WIDTH];
    logic   valid_q [WIDTH];

    for (genvar i = 0; i < WIDTH; i++) begin : g_stage
        stage_t         pay_in;
        stage_t         pay_next;
        logic           valid_in;
        logic [WIDTH:0] shifted;
        logic [WIDTH:0] trial;
        logic           take;

        if (i == 0) begin : g_head
            assign valid_in = op_in.valid;
            assign pay_in = '{
                pr:           {{WIDTH{1'b0}}, op_in.dividend_mag},
                divisor:      op_in.divisor_mag,
                dividend_raw: op_in.dividend_raw,
                flags:        op_in.flags,
                special:      op_in.special,
                tag:          op_in.tag
            };
        end else begin : g_body
            assign valid_in = valid_q[i-1];
            assign pay_in   = pay_q[i-1];
        end

        // partial remainder shifted left, next dividend bit in the lsb.
        // one extra bit since twice the remainder can pass 2**WIDTH.
        assign shifted = pay_in.pr[2*WIDTH-1:WIDTH-1];
        assign trial   = shifted - {1'b0, pay_in.divisor};
        assign take    = (shifted >= {1'b0, pay_in.divisor});

        always_comb begin
            pay_next    = pay_in;
            pay_next.pr = {
                take ? trial[WIDTH-1:0] : shifted[WIDTH-1:0],
                pay_in.pr[WIDTH-2:0],
                take
            };
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                valid_q[i] <= 1'b0;
            end else begin
                valid_q[i] <= valid_in;
            end
        end

        // idle stages shift too.
        always_ff @(posedge clk) begin
            pay_q[i] <= pay_next;
        end
    end

    // upper half is the remainder, lower half the quotient.
    assign res_out.valid        = valid_q[WIDTH-1];
    assign res_out.quot_mag     = pay_q[WIDTH-1].pr[WIDTH-1:0];
    assign res_out.rem_mag      = pay_q[WIDTH-1].pr[2*WIDTH-1:WIDTH];
    assign res_out.dividend_raw = pay_q[WIDTH-1].dividend_raw;
    assign res_out.flags        = pay_q[WIDTH-1].flags;
    assign res_out.special      = pay_q[WIDTH-1].special;
    assign res_out.tag          = pay_q[WIDTH-1].tag;

    a_latency_fwd: assert property (
        @(posedge clk) disable iff (reset)
        op_in.valid |-> ##WIDTH res_out.valid
    ) else $error("divide array dropped an operation");

    a_latency_bwd: assert property (
        @(posedge clk) disable iff (reset)
        res_out.valid |-> $past(op_in.valid, WIDTH)
    ) else $error("divide array produced an extra result");

endmodule

// File: source/div_result_fix.sv
module div_result_fix #(
    parameter int WIDTH = div_pkg::data_width
) (
    input  logic                 clk,
    input  logic                 reset,
    div_res_if.dst               res_in,
    output logic                 done,
    output logic [WIDTH-1:0]     result,
    output cpu_tag_pkg::op_tag_t tag_out
);

    logic [WIDTH-1:0] quot_s;
    logic [WIDTH-1:0] rem_s;
    logic [WIDTH-1:0] quot;
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] result_d;

    assign quot_s = res_in.flags.neg_quot ? -res_in.quot_mag : res_in.quot_mag;
    assign rem_s  = res_in.flags.neg_rem ? -res_in.rem_mag : res_in.rem_mag;

    // fixed risc-v results.
    always_comb begin
        quot = quot_s;
        rem  = rem_s;
        if (res_in.flags.special) begin
            case (res_in.special)
                div_pkg::sp_div_zero: begin
                    quot = '1;
                    rem  = res_in.dividend_raw;
                end
                div_pkg::sp_overflow: begin
                    quot = res_in.dividend_raw;
                    rem  = '0;
                end
                default: ;
            endcase
        end
    end

    assign result_d = res_in.flags.sel_rem ? rem : quot;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done    <= 1'b0;
            result  <= '0;
            tag_out <= '0;
        end else begin
            done <= res_in.valid;
            if (res_in.valid) begin
                result  <= result_d;
                tag_out <= res_in.tag;
            end
        end
    end

    // tag must have survived the whole pipe intact.
    a_tag_known: assert property (
        @(posedge clk) disable iff (reset)
        done |-> !$isunknown(tag_out)
    ) else $error("divide result with unknown tag");

endmodule

// File: source/div_unit.sv
module div_unit #(
    parameter int WIDTH = div_pkg::data_width
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue,
    input  div_pkg::div_op_e                 op,
    input  logic [WIDTH-1:0]                 dividend,
    input  logic [WIDTH-1:0]                 divisor,
    input  logic [cpu_tag_pkg::preg_width-1:0] preg_in,
    input  logic [cpu_tag_pkg::pc_width-1:0]   pc_in,
    output logic                             done,
    output logic [WIDTH-1:0]                 result,
    output logic [cpu_tag_pkg::preg_width-1:0] preg_out,
    output logic [cpu_tag_pkg::pc_width-1:0]   pc_out
);

    cpu_tag_pkg::op_tag_t tag_in;
    cpu_tag_pkg::op_tag_t tag_out;

    div_op_if  #(.WIDTH(WIDTH)) op_bus ();
    div_res_if #(.WIDTH(WIDTH)) res_bus ();

    assign tag_in = '{preg: preg_in, pc: pc_in};

    div_issue_ctrl #(.WIDTH(WIDTH)) i_div_issue_ctrl (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .tag      (tag_in),
        .op_out   (op_bus.src)
    );

    div_array #(.WIDTH(WIDTH)) i_div_array (
        .clk     (clk),
        .reset   (reset),
        .op_in   (op_bus.dst),
        .res_out (res_bus.src)
    );

    div_result_fix #(.WIDTH(WIDTH)) i_div_result_fix (
        .clk     (clk),
        .reset   (reset),
        .res_in  (res_bus.dst),
        .done    (done),
        .result  (result),
        .tag_out (tag_out)
    );

    assign preg_out = tag_out.preg;
    assign pc_out   = tag_out.pc;

endmodule

// File: test/tb_div_unit.sv
module tb_div_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int width       = 32;
    localparam int lat         = width + 2;
    localparam int half_period = 4;
    localparam int drain_limit = 4 * lat + 200;

    localparam logic [width-1:0] most_neg = {1'b1, {(width-1){1'b0}}};

    // expected result of one operation in issue order.
    typedef struct packed {
        logic [width-1:0]                   result;
        logic [cpu_tag_pkg::preg_width-1:0] preg;
        logic [cpu_tag_pkg::pc_width-1:0]   pc;
        logic [31:0]                        due;
    } exp_t;

    logic                             clk;
    logic                             reset;
    logic                             issue;
    div_pkg::div_op_e                 op;
    logic [width-1:0]                 dividend;
    logic [width-1:0]                 divisor;
    logic [cpu_tag_pkg::preg_width-1:0] preg_in;
    logic [cpu_tag_pkg::pc_width-1:0]   pc_in;
    logic                             done;
    logic [width-1:0]                 result;
    logic [cpu_tag_pkg::preg_width-1:0] preg_out;
    logic [cpu_tag_pkg::pc_width-1:0]   pc_out;

    exp_t        exp_q[$];
    exp_t        front;
    logic        front_valid = 1'b0;
    logic        done_seen   = 1'b0;
    logic [31:0] cycle       = '0;
    integer      seed        = 32'h2a2385bb;
    int          errors      = 0;
    int          checks      = 0;
    int          ops_sent    = 0;
    int          tests       = 0;
    logic        timed_out   = 1'b0;

    div_unit #(.WIDTH(width)) i_div_unit (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .preg_in  (preg_in),
        .pc_in    (pc_in),
        .done     (done),
        .result   (result),
        .preg_out (preg_out),
        .pc_out   (pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // risc-v m extension results with truncation toward zero.
    function automatic logic [width-1:0] ref_result(input div_pkg::div_op_e o,
                                                    input logic [width-1:0] a,
                                                    input logic [width-1:0] b);
        logic signed [width-1:0] sa;
        logic signed [width-1:0] sb;
        logic                    ovf;
        logic [width-1:0]        r;
        sa  = a;
        sb  = b;
        ovf = (a == most_neg) && (b == '1);
        r   = '0;
        if (b == '0) begin
            r = (o == div_pkg::op_div || o == div_pkg::op_divu) ? '1 : a;
        end else if (ovf && (o == div_pkg::op_div || o == div_pkg::op_rem)) begin
            r = (o == div_pkg::op_div) ? a : '0;
        end else begin
            case (o)
                div_pkg::op_divu: r = a / b;
                div_pkg::op_remu: r = a % b;
                div_pkg::op_div:  r = sa / sb;
                div_pkg::op_rem:  r = sa % sb;
                default:          r = '0;
            endcase
        end
        return r;
    endfunction

    // reference model of the issues the dut samples.
    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            front_valid <= 1'b0;
            done_seen   <= 1'b0;
            cycle       <= '0;
        end else begin
            if (done && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                checks = checks + 1;
            end
            if (issue) begin
                exp_q.push_back(exp_t'{
                    result: ref_result(op, dividend, divisor),
                    preg:   preg_in,
                    pc:     pc_in,
                    due:    cycle + lat
                });
            end
            front_valid <= (exp_q.size() > 0);
            if (exp_q.size() > 0) begin
                front <= exp_q[0];
            end
            if (done) begin
                done_seen <= 1'b1;
            end
            cycle <= cycle + 1;
        end
    end

    a_done_expected: assert property (
        @(posedge clk) disable iff (reset)
        done |-> front_valid
    ) else begin
        $display("done strobe at %0t with no operation in flight", $time);
        errors = errors + 1;
    end

    a_done_time: assert property (
        @(posedge clk) disable iff (reset)
        done && front_valid |-> cycle == front.due
    ) else begin
        $display("ERR %0t: done at cycle %0d, expected at cycle %0d",
                 $time, $sampled(cycle), $sampled(front.due));
        errors = errors + 1;
    end

    a_no_missed: assert property (
        @(posedge clk) disable iff (reset)
        front_valid && cycle == front.due |-> done
    ) else begin
        $display("no done strobe for the operation due at %0t", $time);
        errors = errors + 1;
    end

    a_result: assert property (
        @(posedge clk) disable iff (reset)
        done && front_valid |-> result == front.result
    ) else begin
        $display("ERR %0t: result %h, expected %h",
                 $time, $sampled(result), $sampled(front.result));
        errors = errors + 1;
    end

    a_tag: assert property (
        @(posedge clk) disable iff (reset)
        done && front_valid |-> preg_out == front.preg && pc_out == front.pc
    ) else begin
        $display("ERR %0t: tag %h/%h, expected %h/%h", $time,
                 $sampled(preg_out), $sampled(pc_out),
                 $sampled(front.preg), $sampled(front.pc));
        errors = errors + 1;
    end

    // outputs stay cleared until the first result.
    a_idle_zero: assert property (
        @(posedge clk) disable iff (reset)
        !done_seen && !done |-> result == '0 && preg_out == '0 && pc_out == '0
    ) else begin
        $display("ERR %0t: outputs not zero before the first result", $time);
        errors = errors + 1;
    end

    task automatic send(input div_pkg::div_op_e o, input logic [width-1:0] a,
                        input logic [width-1:0] b);
        logic [31:0] rnd;
        rnd      = $random(seed);
        issue    = 1'b1;
        op       = o;
        dividend = a;
        divisor  = b;
        preg_in  = rnd[cpu_tag_pkg::preg_width-1:0];
        pc_in    = $random(seed);
        pc_in[1:0] = 2'b00;
        ops_sent = ops_sent + 1;
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < drain_limit) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s, %0d results never came back", name, exp_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic close_test(input string name, input int err0, input int ops0);
        drain(name);
        tests = tests + 1;
        $display("test %-16s %4d ops, %0d errors", name, ops_sent - ops0, errors - err0);
    endtask

    task automatic reset_idle();
        int err0;
        err0 = errors;
        repeat (20) @(negedge clk);
        close_test("reset_idle", err0, ops_sent);
    endtask

    task automatic unsigned_random();
        int          err0;
        int          ops0;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        err0 = errors;
        ops0 = ops_sent;
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            b   = b >> rnd[6:2];
            send(rnd[0] ? div_pkg::op_divu : div_pkg::op_remu, a, b);
            // an idle gap now and then.
            if (rnd[9:8] == 2'b00) begin
                @(negedge clk);
            end
        end
        close_test("unsigned_random", err0, ops0);
    endtask

    // all four sign combinations for both signed ops.
    task automatic send_sign_set(input logic [width-1:0] a_mag, input logic [width-1:0] b_mag);
        logic [width-1:0] a;
        logic [width-1:0] b;
        for (int i = 0; i < 4; i++) begin
            a = i[0] ? -a_mag : a_mag;
            b = i[1] ? -b_mag : b_mag;
            send(div_pkg::op_div, a, b);
            send(div_pkg::op_rem, a, b);
        end
    endtask

    task automatic signed_combos();
        int          err0;
        int          ops0;
        logic [31:0] rnd;
        logic [31:0] a;
        err0 = errors;
        ops0 = ops_sent;
        send_sign_set(32'd7, 32'd2);
        send_sign_set(32'd6, 32'd3);
        send_sign_set(32'd1, 32'd5);
        send_sign_set(32'h7fff_ffff, 32'd3);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            a[31] = 1'b0;
            send_sign_set(a, (a >> rnd[4:0]) | 32'd1);
        end
        close_test("signed_signs", err0, ops0);
    endtask

    task automatic special_cases();
        int               err0;
        int               ops0;
        logic [width-1:0] vals[5];
        err0 = errors;
        ops0 = ops_sent;
        vals[0] = '0;
        vals[1] = 32'd1;
        vals[2] = most_neg;
        vals[3] = '1;
        vals[4] = $random(seed);
        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < 4; k++) begin
                send(div_pkg::div_op_e'(k[1:0]), vals[i], '0);
            end
        end
        for (int k = 0; k < 4; k++) begin
            send(div_pkg::div_op_e'(k[1:0]), most_neg, '1);
        end
        close_test("special_cases", err0, ops0);
    endtask

    task automatic single_latency();
        int err0;
        int ops0;
        err0 = errors;
        ops0 = ops_sent;
        send(div_pkg::op_divu, 32'd1000, 32'd7);
        drain("single_latency");
        send(div_pkg::op_rem, -32'd1000, 32'd7);
        close_test("single_latency", err0, ops0);
    endtask

    task automatic back_to_back_burst();
        int          err0;
        int          ops0;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        err0 = errors;
        ops0 = ops_sent;
        for (int i = 0; i < 3 * lat; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            send(div_pkg::div_op_e'(rnd[1:0]), a, b >> rnd[6:2]);
        end
        close_test("burst", err0, ops0);
    endtask

    initial begin
        reset    = 1'b1;
        issue    = 1'b0;
        op       = div_pkg::op_divu;
        dividend = '0;
        divisor  = '0;
        preg_in  = '0;
        pc_in    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_idle();
        if (!timed_out) unsigned_random();
        if (!timed_out) signed_combos();
        if (!timed_out) special_cases();
        if (!timed_out) single_latency();
        if (!timed_out) back_to_back_burst();

        $display("tests %0d, operations %0d, results checked %0d, errors %0d",
                 tests, ops_sent, checks, errors);
        if (errors == 0 && !timed_out && checks == ops_sent) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: flist.f
source/div_pkg.sv
source/cpu_tag_pkg.sv
source/div_if.sv
source/div_issue_ctrl.sv
source/div_array.sv
source/div_result_fix.sv
source/div_unit.sv
test/tb_div_unit.sv

// File: run.sh
#!/bin/sh
# build and run the divide unit testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_div_unit \
    -f flist.f

output=$(./obj_dir/Vtb_div_unit)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
